//--- hw/tcb_pkg.sv
/* TCB bus protocol definitions
   request and response words and the transfer size encoding */

package tcb_pkg;

  //////////////////////////////////////////////////////////////////////
  // bus geometry
  //////////////////////////////////////////////////////////////////////

  // data bus width
  localparam int unsigned DBW = 32;
  // address width
  localparam int unsigned ABW = 32;
  // byte lanes per data word
  localparam int unsigned BEW = DBW / 8;

  //////////////////////////////////////////////////////////////////////
  // transfer size, log2 of the byte count
  //////////////////////////////////////////////////////////////////////

  typedef logic [1:0] tcb_siz_t;

  localparam tcb_siz_t SIZ_BYTE = 2'd0;
  localparam tcb_siz_t SIZ_HALF = 2'd1;
  localparam tcb_siz_t SIZ_WORD = 2'd2;

  // request, one cycle strobe, no handshake
  typedef struct packed {
    logic           trn;  // transfer strobe
    logic           wen;  // write enable
    logic           uns;  // unsigned read
    tcb_siz_t       siz;
    logic [ABW-1:0] adr;
    logic [DBW-1:0] wdt;
  } tcb_req_t;

  // response, one strobe per transfer
  typedef struct packed {
    logic           vld;
    logic           err;  // misaligned access
    logic [DBW-1:0] rdt;
  } tcb_rsp_t;

endpackage

//--- hw/mem_pkg.sv
/* memory internals
   decoded access word and read tracking tag */

package mem_pkg;

  import tcb_pkg::*;

  // byte offset bits within a word
  localparam int unsigned OFW = $clog2(BEW);
  // word row index bits before folding into the array
  localparam int unsigned RWW = ABW - OFW;

  //////////////////////////////////////////////////////////////////////
  // decode output, consumed by array
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic           vld;
    logic           wen;
    logic           err;
    logic [RWW-1:0] row;  // word index, already folded
    logic [BEW-1:0] ben;  // lane enables, zero on error
    logic [DBW-1:0] wdt;  // data placed on its lanes
    logic [OFW-1:0] off;
    tcb_siz_t       siz;
    logic           uns;
  } mem_acc_t;

  // per transfer tag, travels with the read word
  typedef struct packed {
    logic           vld;
    logic           err;
    logic [OFW-1:0] off;
    tcb_siz_t       siz;
    logic           uns;
  } mem_rtag_t;

endpackage

//--- hw/tcb_mem_decode.sv
/* TCB memory request decoder
   lane enables, lane placed write data, row index and alignment check */

`timescale 1ns/100ps

module tcb_mem_decode
  import tcb_pkg::*;
  import mem_pkg::*;
#(
  int unsigned SZ = 1024
)(
  input  tcb_req_t req,
  output mem_acc_t acc
);

  // words in the array
  localparam int unsigned RWN = SZ / BEW;

  //////////////////////////////////////////////////////////////////////
  // local signals
  //////////////////////////////////////////////////////////////////////

  logic [OFW-1:0]      off;
  // index of the last byte inside the transfer
  logic [OFW-1:0]      lst;
  logic                mis;
  logic                bad;
  logic [BEW-1:0]      ben;
  logic [BEW-1:0][7:0] req_byt;
  logic [BEW-1:0][7:0] lan_byt;

  assign off     = req.adr[OFW-1:0];
  assign req_byt = req.wdt;

  // byte count minus one, 0/1/3
  assign lst = OFW'((1 << req.siz) - 1);

  // low address bits inside the transfer must be zero
  assign mis = |(off & lst);
  // sizes wider than the bus are refused as well
  assign bad = int'(req.siz) > OFW;

  //////////////////////////////////////////////////////////////////////
  // lane mapping
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int b = 0; b < BEW; b++) begin
      // lane is hit when its bits above the size match the offset
      ben[b]     = ((OFW'(b) ^ off) & ~lst) == '0;
      // replicate so every hit lane holds its own byte
      lan_byt[b] = req_byt[OFW'(b) & lst];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // decoded access
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    acc.vld = req.trn;
    acc.wen = req.wen;
    acc.err = mis | bad;
    // fold into the array, address wraps at SZ
    acc.row = req.adr[ABW-1:OFW] & RWW'(RWN - 1);
    // nothing gets written on an error
    acc.ben = (mis | bad) ? '0 : ben;
    acc.wdt = lan_byt;
    acc.off = off;
    acc.siz = req.siz;
    acc.uns = req.uns;
  end

endmodule

//--- hw/tcb_mem_array.sv
/* TCB memory storage
   byte lane array with lane masked writes and registered row reads */

`timescale 1ns/100ps

module tcb_mem_array
  import tcb_pkg::*;
  import mem_pkg::*;
#(
  int unsigned SZ = 1024
)(
  input  logic           tcb,
  input  logic           rst_n,
  input  mem_acc_t       acc,
  output logic [DBW-1:0] rdw,
  output mem_rtag_t      rtag
);

  localparam int unsigned RWN = SZ / BEW;
  localparam int unsigned IXW = $clog2(RWN);

  //////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////

  logic [BEW-1:0][7:0] mem [RWN];

  logic [IXW-1:0]      idx;
  logic [BEW-1:0][7:0] wdt_byt;

  // row already folded by decode, keep the low bits
  assign idx     = acc.row[IXW-1:0];
  assign wdt_byt = acc.wdt;

  // write, only the enabled lanes
  always_ff @(posedge tcb) begin
    if (acc.vld && acc.wen && !acc.err) begin
      for (int b = 0; b < BEW; b++) begin
        if (acc.ben[b]) begin
          mem[idx][b] <= wdt_byt[b];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read word and tag
  //////////////////////////////////////////////////////////////////////

  // whole row, realigned later
  // writes load zero so their response data stays clear
  always_ff @(posedge tcb) begin
    if (acc.vld) begin
      rdw <= acc.wen ? '0 : mem[idx];
    end
  end

  // tag for every transfer, reads and writes
  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      rtag.vld <= 1'b0;
    end else begin
      rtag.vld <= acc.vld;
    end
    if (acc.vld) begin
      rtag.err <= acc.err;
      rtag.off <= acc.off;
      rtag.siz <= acc.siz;
      rtag.uns <= acc.uns;
    end
  end

endmodule

//--- hw/tcb_mem_result.sv
/* TCB memory response stage
   read delay line, byte realignment, sign or zero extension */

`timescale 1ns/100ps

module tcb_mem_result
  import tcb_pkg::*;
  import mem_pkg::*;
#(
  int unsigned DLY = 2
)(
  input  logic           tcb,
  input  logic           rst_n,
  input  logic [DBW-1:0] rdw,
  input  mem_rtag_t      rtag,
  output tcb_rsp_t       rsp
);

  //////////////////////////////////////////////////////////////////////
  // delay line
  //////////////////////////////////////////////////////////////////////

  // stage 0 is the array register, the rest are local
  logic [DBW-1:0] stg_rdw [DLY];
  mem_rtag_t      stg_tag [DLY];

  assign stg_rdw[0] = rdw;
  assign stg_tag[0] = rtag;

  // no stages at all for DLY of 1
  for (genvar d = 1; d < DLY; d++) begin : g_stg
    always_ff @(posedge tcb) begin
      if (!rst_n) begin
        stg_tag[d].vld <= 1'b0;
      end else begin
        stg_tag[d] <= stg_tag[d-1];
      end
      stg_rdw[d] <= stg_rdw[d-1];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // realign and extend
  //////////////////////////////////////////////////////////////////////

  mem_rtag_t      tag;
  logic [DBW-1:0] shf;
  logic [DBW-1:0] ext;
  logic           sgn;

  assign tag = stg_tag[DLY-1];

  // addressed byte down to lane 0
  assign shf = stg_rdw[DLY-1] >> {tag.off, 3'b000};

  // sign extension only for signed reads
  assign sgn = ~tag.uns;

  always_comb begin
    case (tag.siz)
      SIZ_BYTE: ext = {{(DBW-8){sgn & shf[7]}}, shf[7:0]};
      SIZ_HALF: ext = {{(DBW-16){sgn & shf[15]}}, shf[15:0]};
      // full word passes as is
      default:  ext = shf;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    rsp.vld = tag.vld;
    // stale tag fields while idle, hence the gating
    rsp.err = tag.vld & tag.err;
    rsp.rdt = (tag.vld && !tag.err) ? ext : '0;
  end

endmodule

//--- hw/tcb_mem_top.sv
/* TCB memory, single subordinate port
   fixed latency responses, misaligned accesses return an error */

`timescale 1ns/100ps

module tcb_mem_top
  import tcb_pkg::*;
  import mem_pkg::*;
#(
  // size in bytes, power of two
  int unsigned SZ  = 1024,
  // read latency in cycles
  int unsigned DLY = 2
)(
  input  logic     tcb,
  input  logic     rst_n,
  input  tcb_req_t req,
  output tcb_rsp_t rsp
);

  mem_acc_t       acc;
  logic [DBW-1:0] rdw;
  mem_rtag_t      rtag;

  // request decode, combinational
  tcb_mem_decode #(
    .SZ (SZ)
  ) tcb_mem_decode_i (
    .req (req),
    .acc (acc)
  );

  // storage, one cycle read
  tcb_mem_array #(
    .SZ (SZ)
  ) tcb_mem_array_i (
    .tcb   (tcb),
    .rst_n (rst_n),
    .acc   (acc),
    .rdw   (rdw),
    .rtag  (rtag)
  );

  // remaining DLY-1 cycles and response forming
  tcb_mem_result #(
    .DLY (DLY)
  ) tcb_mem_result_i (
    .tcb   (tcb),
    .rst_n (rst_n),
    .rdw   (rdw),
    .rtag  (rtag),
    .rsp   (rsp)
  );

endmodule

//--- verif/tcb_mem_ref.svh
/* TCB memory reference model
   byte array with the lane write rule, expected response per request */

`ifndef TCB_MEM_REF_SVH
`define TCB_MEM_REF_SVH

// one entry per byte address, folded at SZ
logic [7:0] ref_mem [SZ];

// byte count of a transfer size
function automatic int unsigned size_bytes(input tcb_siz_t siz);
  return 1 << siz;
endfunction

// address must be a multiple of the byte count
function automatic bit is_misaligned(input tcb_req_t r);
  return (r.adr % size_bytes(r.siz)) != 0;
endfunction

// apply one request to the model and return the response it should get
function automatic tcb_rsp_t model_access(input tcb_req_t r);
  tcb_rsp_t       exp;
  int unsigned    n;
  int unsigned    a;
  logic [DBW-1:0] val;
  n   = size_bytes(r.siz);
  a   = r.adr % SZ;
  exp = '0;
  exp.vld = 1'b1;
  if (is_misaligned(r)) begin
    // refused, memory untouched, no data
    exp.err = 1'b1;
  end else if (r.wen) begin
    // write data sits in the low bytes of wdt
    for (int i = 0; i < n; i++) begin
      ref_mem[a+i] = r.wdt[8*i +: 8];
    end
  end else begin
    val = '0;
    for (int i = 0; i < n; i++) begin
      val[8*i +: 8] = ref_mem[a+i];
    end
    // extend from the top byte read
    if (!r.uns && val[8*n-1]) begin
      for (int i = 8 * n; i < DBW; i++) begin
        val[i] = 1'b1;
      end
    end
    exp.rdt = val;
  end
  return exp;
endfunction

`endif

//--- verif/tcb_mem_tb.sv
/* TCB memory testbench
   random traffic checked against a byte model, latency and data */

`timescale 1ns/100ps

module tcb_mem_tb
  import tcb_pkg::*;
();

  localparam int unsigned SZ  = 256;
  localparam int unsigned DLY = 2;

  logic     tcb;
  logic     rst_n;
  tcb_req_t req;
  tcb_rsp_t rsp;

  `include "tcb_mem_ref.svh"

  tcb_mem_top #(
    .SZ  (SZ),
    .DLY (DLY)
  ) tcb_mem_top_i (
    .tcb   (tcb),
    .rst_n (rst_n),
    .req   (req),
    .rsp   (rsp)
  );

  // 10 ns clock
  initial tcb = 1'b0;
  always #5 tcb = ~tcb;

  ////////////////////////////////////////////////////////////////////
  // bookkeeping
  ////////////////////////////////////////////////////////////////////

  int unsigned cyc;
  int unsigned errors;
  int unsigned n_req;
  int unsigned n_rsp;
  bit          timed_out;
  // due cycle per outstanding response
  int unsigned due_q [$];
  tcb_rsp_t    exp_q [$];
  logic [31:0] rnd_state;

  // xorshift32
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rnd_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rnd_state = x;
    return x;
  endfunction

  function automatic tcb_req_t make_req(input logic wen, input logic uns,
                                        input tcb_siz_t siz, input logic [ABW-1:0] adr,
                                        input logic [DBW-1:0] wdt);
    tcb_req_t r;
    r.trn = 1'b1;
    r.wen = wen;
    r.uns = uns;
    r.siz = siz;
    r.adr = adr;
    r.wdt = wdt;
    return r;
  endfunction

  // responses are sampled mid cycle on the falling edge
  task automatic check_response();
    logic     due;
    tcb_rsp_t exp;
    due = (due_q.size() > 0) && (due_q[0] == cyc);
    // strobe exactly DLY cycles after each request
    assert (rsp.vld === due) else begin
      errors++;
      $display("[ERROR] %0t: rsp.vld %b, expected %b", $time, rsp.vld, due);
    end
    if (due) begin
      void'(due_q.pop_front());
      exp = exp_q.pop_front();
      if (rsp.vld === 1'b1) begin
        n_rsp++;
      end
      assert (rsp.err === exp.err && rsp.rdt === exp.rdt) else begin
        errors++;
        $display("[ERROR] %0t: err %b rdt %h, expected err %b rdt %h",
                 $time, rsp.err, rsp.rdt, exp.err, exp.rdt);
      end
    end
  endtask

  // check the response then drive the next request
  task automatic step(input tcb_req_t r);
    @(negedge tcb);
    cyc++;
    check_response();
    req = r;
    if (r.trn) begin
      n_req++;
      due_q.push_back(cyc + DLY);
      exp_q.push_back(model_access(r));
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] x;
    logic [31:0] a;
    tcb_siz_t    s;
    int unsigned t;
    rnd_state = 32'd20;
    cyc       = 0;
    errors    = 0;
    n_req     = 0;
    n_rsp     = 0;
    timed_out = 1'b0;
    req       = '0;
    rst_n     = 1'b0;
    // strobe must stay low through reset
    for (int c = 0; c < 4; c++) begin
      @(negedge tcb);
      assert (rsp.vld === 1'b0) else begin
        errors++;
        $display("[ERROR] %0t: rsp.vld %b during reset, expected 0", $time, rsp.vld);
      end
    end
    rst_n = 1'b1;

    // fill every word so the model is fully known
    for (int w = 0; w < SZ / BEW; w++) begin
      step(make_req(1'b1, 1'b0, SIZ_WORD, w * BEW, next_rand()));
    end

    // narrow writes each followed at once by a word read
    step(make_req(1'b1, 1'b0, SIZ_BYTE, 32'h0000_000d, 32'h0000_0085));
    step(make_req(1'b0, 1'b0, SIZ_WORD, 32'h0000_000c, '0));
    step(make_req(1'b1, 1'b0, SIZ_HALF, 32'h0000_0012, 32'h0000_8123));
    step(make_req(1'b0, 1'b0, SIZ_WORD, 32'h0000_0010, '0));
    // signed and unsigned reads of byte and half
    step(make_req(1'b0, 1'b0, SIZ_BYTE, 32'h0000_000d, '0));
    step(make_req(1'b0, 1'b1, SIZ_BYTE, 32'h0000_000d, '0));
    step(make_req(1'b0, 1'b0, SIZ_HALF, 32'h0000_0012, '0));
    step(make_req(1'b0, 1'b1, SIZ_HALF, 32'h0000_0012, '0));
    // misaligned write and read followed by a read of the row
    step(make_req(1'b1, 1'b0, SIZ_HALF, 32'h0000_0021, 32'hffff_ffff));
    step(make_req(1'b0, 1'b0, SIZ_WORD, 32'h0000_0022, '0));
    step('0);
    step(make_req(1'b0, 1'b0, SIZ_WORD, 32'h0000_0020, '0));

    // random mix with occasional idle gaps
    for (int i = 0; i < 400; i++) begin
      x = next_rand();
      if (x[3:0] == 4'd0) begin
        repeat (1 + x[12:11]) step('0);
      end else begin
        s = tcb_siz_t'(x[6:5] % 3);
        a = next_rand();
        // mostly aligned with upper bits left random to exercise the wrap
        if (x[9:7] != 3'd0) begin
          a = a & ~((32'd1 << s) - 1);
        end
        step(make_req(x[4], x[10], s, a, next_rand()));
      end
    end

    // drain outstanding responses
    t = 0;
    while (due_q.size() > 0 && !timed_out) begin
      step('0);
      t++;
      if (t > 4 * DLY + 4) begin
        timed_out = 1'b1;
        $display("timeout: %0d responses still outstanding after %0d idle cycles",
                 due_q.size(), t);
      end
    end
    // no stray strobes while idle
    repeat (4) step('0);

    assert (n_rsp == n_req) else begin
      errors++;
      $display("[ERROR] %0t: response count %0d, expected %0d", $time, n_rsp, n_req);
    end

    $display("errors: %0d, requests: %0d, responses: %0d", errors, n_req, n_rsp);
    if (errors == 0 && !timed_out) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+verif
hw/tcb_pkg.sv
hw/mem_pkg.sv
hw/tcb_mem_decode.sv
hw/tcb_mem_array.sv
hw/tcb_mem_result.sv
hw/tcb_mem_top.sv
verif/tcb_mem_tb.sv
